//--- cpu_isa_pkg.sv
package cpu_isa_pkg;

  // Supported subset of the 6502 opcode map
  typedef enum logic [7:0] {
    OP_CLC     = 8'h18,
    OP_SEC     = 8'h38,
    OP_JMP_ABS = 8'h4C,
    OP_ADC_IMM = 8'h69,
    OP_STA_ZP  = 8'h85,
    OP_TXA     = 8'h8A,
    OP_TYA     = 8'h98,
    OP_TXS     = 8'h9A,
    OP_LDY_IMM = 8'hA0,
    OP_LDX_IMM = 8'hA2,
    OP_LDY_ZP  = 8'hA4,
    OP_LDA_ZP  = 8'hA5,
    OP_LDX_ZP  = 8'hA6,
    OP_TAY     = 8'hA8,
    OP_LDA_IMM = 8'hA9,
    OP_TAX     = 8'hAA,
    OP_TSX     = 8'hBA,
    OP_CMP_IMM = 8'hC9,
    OP_SBC_IMM = 8'hE9,
    OP_NOP     = 8'hEA
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADC,
    ALU_SBC,
    ALU_CMP,
    ALU_NONE
  } alu_op_e;

  typedef enum logic [2:0] {
    STAGE_FETCH,
    STAGE_OPERAND,
    STAGE_FINISH,
    STAGE_VECTOR_LOW,
    STAGE_VECTOR_HIGH
  } stage_e;

  typedef struct packed {
    logic n;
    logic v;
    logic unused;
    logic b;
    logic d;
    logic i;
    logic z;
    logic c;
  } status_flags_t;

  // P register, seen as a byte or as individual flags
  typedef union packed {
    logic [7:0]    raw;
    status_flags_t flags;
  } status_u;

  localparam logic [7:0]  STATUS_RESET     = 8'h34;
  localparam logic [15:0] VECTOR_LOW_ADDR  = 16'hFFFC;
  localparam logic [15:0] VECTOR_HIGH_ADDR = 16'hFFFD;

endpackage

//--- cpu_bus_pkg.sv
package cpu_bus_pkg;
  import cpu_isa_pkg::*;

  localparam int ADDR_WIDTH   = 16;
  localparam int DATA_WIDTH   = 8;
  // Clock cycles per bus step
  localparam int STEP_DIVIDER = 12;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] address;
    logic [DATA_WIDTH-1:0] write_data;
    logic                  read;
    logic                  write;
  } bus_req_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] x;
    logic [DATA_WIDTH-1:0] y;
    logic [DATA_WIDTH-1:0] sp;
    status_u               status;
  } cpu_regs_t;

  typedef enum logic [2:0] {
    DEST_NONE,
    DEST_A,
    DEST_X,
    DEST_Y,
    DEST_SP
  } dest_sel_e;

  typedef enum logic [2:0] {
    SRC_DATA,
    SRC_A,
    SRC_X,
    SRC_SP,
    SRC_Y,
    SRC_HOLD
  } src_sel_e;

  typedef enum logic [2:0] {
    ADDR_KEEP,
    ADDR_PC_PLUS_ONE,
    ADDR_ZERO_PAGE,
    ADDR_VECTOR_HIGH,
    ADDR_JUMP_TARGET
  } addr_sel_e;

  typedef struct packed {
    logic      advance;
    dest_sel_e dest;
    src_sel_e  src;
    logic      set_carry;
    logic      clear_carry;
    logic      flags_from_data;
    logic      flags_from_alu;
    alu_op_e   alu_op;
    logic      hold_from_alu;
    logic      pc_increment;
    logic      pc_low_from_data;
    logic      pc_high_from_data;
    addr_sel_e addr_sel;
    logic      read;
    logic      write;
    logic      out_from_a;
  } ctrl_t;

endpackage

//--- step_timer.sv
module step_timer
  import cpu_bus_pkg::*;
(
  input  logic clock_i,
  input  logic reset_i,
  output logic step_o
);

  logic [$clog2(STEP_DIVIDER)-1:0] count_q;

  // One strobe per wrap of the counter
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      count_q <= '0;
      step_o  <= 1'b0;
    end else if (count_q == STEP_DIVIDER - 1) begin
      count_q <= '0;
      step_o  <= 1'b1;
    end else begin
      count_q <= count_q + 1'b1;
      step_o  <= 1'b0;
    end
  end

endmodule

//--- cpu_alu.sv
module cpu_alu
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  alu_op_e               op_i,
  input  status_u               status_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output status_u               alu_status_o,
  output status_u               data_status_o
);

  logic [DATA_WIDTH-1:0] operand;
  logic                  carry_in;
  logic [DATA_WIDTH:0]   sum;

  always_comb begin
    operand  = b_i;
    carry_in = status_i.flags.c;
    case (op_i)
      // Borrow is the inverted carry
      ALU_SBC: operand = ~b_i;
      ALU_CMP: begin
        operand  = ~b_i;
        carry_in = 1'b1;
      end
      default: ;
    endcase

    sum      = {1'b0, a_i} + {1'b0, operand} + {{DATA_WIDTH{1'b0}}, carry_in};
    result_o = sum[DATA_WIDTH-1:0];

    alu_status_o = status_i;
    if (op_i != ALU_NONE) begin
      alu_status_o.flags.c = sum[DATA_WIDTH];
      alu_status_o.flags.z = (sum[DATA_WIDTH-1:0] == '0);
      alu_status_o.flags.n = sum[DATA_WIDTH-1];
      // No overflow logic yet
      alu_status_o.flags.v = 1'b0;
    end
  end

  // Load flags clear everything else
  always_comb begin
    data_status_o         = '0;
    data_status_o.flags.z = (data_i == '0);
    data_status_o.flags.n = data_i[DATA_WIDTH-1];
  end

endmodule

//--- cpu_control.sv
module cpu_control
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  logic                  step_i,
  input  logic                  data_valid_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  output ctrl_t                 ctrl_o
);

  stage_e    stage_q;
  stage_e    stage_next;
  opcode_e   opcode_q;
  logic      ready;
  logic      goto_fetch;
  logic      fetch_implied;
  dest_sel_e load_dest;

  // Single-byte opcodes need no operand fetch
  always_comb begin
    case (data_i)
      OP_NOP, OP_SEC, OP_CLC, OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX:
        fetch_implied = 1'b1;
      default: fetch_implied = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode_q)
      OP_LDA_IMM, OP_LDA_ZP: load_dest = DEST_A;
      OP_LDX_IMM, OP_LDX_ZP: load_dest = DEST_X;
      OP_LDY_IMM, OP_LDY_ZP: load_dest = DEST_Y;
      default:               load_dest = DEST_NONE;
    endcase
  end

  always_comb begin
    ctrl_o        = '0;
    ctrl_o.alu_op = ALU_NONE;
    ready         = 1'b0;
    goto_fetch    = 1'b0;
    stage_next    = stage_q;

    case (stage_q)
      STAGE_VECTOR_LOW: begin
        ready                   = data_valid_i;
        ctrl_o.pc_low_from_data = 1'b1;
        ctrl_o.addr_sel         = ADDR_VECTOR_HIGH;
        ctrl_o.read             = 1'b1;
        stage_next              = STAGE_VECTOR_HIGH;
      end

      STAGE_VECTOR_HIGH: begin
        ready                    = data_valid_i;
        ctrl_o.pc_high_from_data = 1'b1;
        ctrl_o.addr_sel          = ADDR_JUMP_TARGET;
        ctrl_o.read              = 1'b1;
        stage_next               = STAGE_FETCH;
      end

      STAGE_FETCH: begin
        ready       = data_valid_i;
        ctrl_o.read = 1'b1;
        stage_next  = STAGE_OPERAND;
        if (!fetch_implied) begin
          ctrl_o.pc_increment = 1'b1;
          ctrl_o.addr_sel     = ADDR_PC_PLUS_ONE;
        end
        // Deferred ADC/SBC result lands in A here
        if (opcode_q == OP_ADC_IMM || opcode_q == OP_SBC_IMM) begin
          ctrl_o.dest = DEST_A;
          ctrl_o.src  = SRC_HOLD;
        end
      end

      STAGE_OPERAND: begin
        case (opcode_q)
          OP_NOP: begin
            ready      = 1'b1;
            goto_fetch = 1'b1;
          end
          OP_SEC, OP_CLC: begin
            ready              = 1'b1;
            goto_fetch         = 1'b1;
            ctrl_o.set_carry   = (opcode_q == OP_SEC);
            ctrl_o.clear_carry = (opcode_q == OP_CLC);
          end
          OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX: begin
            ready      = 1'b1;
            goto_fetch = 1'b1;
            case (opcode_q)
              OP_TAX: {ctrl_o.dest, ctrl_o.src} = {DEST_X, SRC_A};
              OP_TAY: {ctrl_o.dest, ctrl_o.src} = {DEST_Y, SRC_A};
              OP_TXA: {ctrl_o.dest, ctrl_o.src} = {DEST_A, SRC_X};
              OP_TYA: {ctrl_o.dest, ctrl_o.src} = {DEST_A, SRC_Y};
              OP_TXS: {ctrl_o.dest, ctrl_o.src} = {DEST_SP, SRC_X};
              default: {ctrl_o.dest, ctrl_o.src} = {DEST_X, SRC_SP};
            endcase
          end
          OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
            ready                  = data_valid_i;
            goto_fetch             = 1'b1;
            ctrl_o.dest            = load_dest;
            ctrl_o.src             = SRC_DATA;
            ctrl_o.flags_from_data = 1'b1;
          end
          OP_ADC_IMM, OP_SBC_IMM, OP_CMP_IMM: begin
            ready                 = data_valid_i;
            goto_fetch            = 1'b1;
            ctrl_o.flags_from_alu = 1'b1;
            ctrl_o.hold_from_alu  = (opcode_q != OP_CMP_IMM);
            case (opcode_q)
              OP_ADC_IMM: ctrl_o.alu_op = ALU_ADC;
              OP_SBC_IMM: ctrl_o.alu_op = ALU_SBC;
              default:    ctrl_o.alu_op = ALU_CMP;
            endcase
          end
          OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
            ready           = data_valid_i;
            ctrl_o.addr_sel = ADDR_ZERO_PAGE;
            ctrl_o.read     = 1'b1;
            stage_next      = STAGE_FINISH;
          end
          OP_STA_ZP: begin
            ready             = data_valid_i;
            ctrl_o.addr_sel   = ADDR_ZERO_PAGE;
            ctrl_o.write      = 1'b1;
            ctrl_o.out_from_a = 1'b1;
            stage_next        = STAGE_FINISH;
          end
          OP_JMP_ABS: begin
            ready                   = data_valid_i;
            ctrl_o.pc_low_from_data = 1'b1;
            ctrl_o.addr_sel         = ADDR_PC_PLUS_ONE;
            ctrl_o.read             = 1'b1;
            stage_next              = STAGE_FINISH;
          end
          // Unknown opcode stalls here
          default: ready = 1'b0;
        endcase
      end

      STAGE_FINISH: begin
        case (opcode_q)
          OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP: begin
            ready                  = data_valid_i;
            goto_fetch             = 1'b1;
            ctrl_o.dest            = load_dest;
            ctrl_o.src             = SRC_DATA;
            ctrl_o.flags_from_data = 1'b1;
          end
          OP_STA_ZP: begin
            ready      = 1'b1;
            goto_fetch = 1'b1;
          end
          OP_JMP_ABS: begin
            ready                    = data_valid_i;
            ctrl_o.pc_high_from_data = 1'b1;
            ctrl_o.addr_sel          = ADDR_JUMP_TARGET;
            ctrl_o.read              = 1'b1;
            stage_next               = STAGE_FETCH;
          end
          default: ready = 1'b0;
        endcase
      end

      default: ready = 1'b0;
    endcase

    // Common tail: move on to the next opcode
    if (goto_fetch) begin
      ctrl_o.pc_increment = 1'b1;
      ctrl_o.addr_sel     = ADDR_PC_PLUS_ONE;
      ctrl_o.read         = 1'b1;
      stage_next          = STAGE_FETCH;
    end

    ctrl_o.advance = step_i & ready;
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      stage_q  <= STAGE_VECTOR_LOW;
      opcode_q <= OP_NOP;
    end else if (ctrl_o.advance) begin
      stage_q <= stage_next;
      if (stage_q == STAGE_FETCH) begin
        opcode_q <= opcode_e'(data_i);
      end
    end
  end

endmodule

//--- cpu_datapath.sv
module cpu_datapath
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  ctrl_t                 ctrl_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic [DATA_WIDTH-1:0] alu_result_i,
  input  status_u               alu_status_i,
  input  status_u               data_status_i,
  output cpu_regs_t             regs_o,
  output bus_req_t              bus_o
);

  logic [DATA_WIDTH-1:0] a_q;
  logic [DATA_WIDTH-1:0] x_q;
  logic [DATA_WIDTH-1:0] y_q;
  logic [DATA_WIDTH-1:0] sp_q;
  logic [DATA_WIDTH-1:0] hold_q;
  logic [DATA_WIDTH-1:0] write_data_q;
  logic [DATA_WIDTH-1:0] src_value;
  status_u               status_q;
  status_u               status_next;
  logic [ADDR_WIDTH-1:0] pc_q;
  logic [ADDR_WIDTH-1:0] pc_next;
  logic [ADDR_WIDTH-1:0] pc_plus_one;
  logic [ADDR_WIDTH-1:0] address_q;
  logic [ADDR_WIDTH-1:0] address_next;
  logic                  read_q;
  logic                  write_q;

  assign pc_plus_one = pc_q + 1'b1;

  always_comb begin
    case (ctrl_i.src)
      SRC_A:    src_value = a_q;
      SRC_X:    src_value = x_q;
      SRC_Y:    src_value = y_q;
      SRC_SP:   src_value = sp_q;
      SRC_HOLD: src_value = hold_q;
      default:  src_value = data_i;
    endcase
  end

  always_comb begin
    status_next = status_q;
    if (ctrl_i.flags_from_alu) begin
      status_next = alu_status_i;
    end
    if (ctrl_i.flags_from_data) begin
      status_next = data_status_i;
    end
    if (ctrl_i.set_carry) begin
      status_next.flags.c = 1'b1;
    end
    if (ctrl_i.clear_carry) begin
      status_next.flags.c = 1'b0;
    end
  end

  always_comb begin
    pc_next = pc_q;
    if (ctrl_i.pc_increment) begin
      pc_next = pc_plus_one;
    end
    if (ctrl_i.pc_low_from_data) begin
      pc_next[DATA_WIDTH-1:0] = data_i;
    end
    if (ctrl_i.pc_high_from_data) begin
      pc_next[ADDR_WIDTH-1:DATA_WIDTH] = data_i;
    end
  end

  always_comb begin
    case (ctrl_i.addr_sel)
      ADDR_PC_PLUS_ONE: address_next = pc_plus_one;
      ADDR_ZERO_PAGE:   address_next = {{(ADDR_WIDTH - DATA_WIDTH){1'b0}}, data_i};
      ADDR_VECTOR_HIGH: address_next = VECTOR_HIGH_ADDR;
      // Low byte was captured into the PC one step earlier
      ADDR_JUMP_TARGET: address_next = {data_i, pc_q[DATA_WIDTH-1:0]};
      default:          address_next = address_q;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      a_q       <= '0;
      x_q       <= '0;
      y_q       <= '0;
      sp_q      <= '0;
      status_q  <= STATUS_RESET;
      pc_q      <= '0;
      address_q <= VECTOR_LOW_ADDR;
      read_q    <= 1'b1;
      write_q   <= 1'b0;
    end else if (ctrl_i.advance) begin
      case (ctrl_i.dest)
        DEST_A:  a_q <= src_value;
        DEST_X:  x_q <= src_value;
        DEST_Y:  y_q <= src_value;
        DEST_SP: sp_q <= src_value;
        default: ;
      endcase
      status_q  <= status_next;
      pc_q      <= pc_next;
      address_q <= address_next;
      read_q    <= ctrl_i.read;
      write_q   <= ctrl_i.write;
    end
  end

  always_ff @(posedge clock_i) begin
    if (ctrl_i.advance) begin
      if (ctrl_i.hold_from_alu) begin
        hold_q <= alu_result_i;
      end
      if (ctrl_i.out_from_a) begin
        write_data_q <= a_q;
      end
    end
  end

  always_comb begin
    bus_o.address    = address_q;
    bus_o.write_data = write_data_q;
    bus_o.read       = read_q;
    bus_o.write      = write_q;

    regs_o.pc     = pc_q;
    regs_o.a      = a_q;
    regs_o.x      = x_q;
    regs_o.y      = y_q;
    regs_o.sp     = sp_q;
    regs_o.status = status_q;
  end

endmodule

//--- cpu_top.sv
module cpu_top
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  reset_i,
  input  logic [DATA_WIDTH-1:0] data_i,
  input  logic                  data_valid_i,
  output bus_req_t              bus_o,
  output cpu_regs_t             regs_o
);

  logic                  step;
  ctrl_t                 ctrl;
  logic [DATA_WIDTH-1:0] alu_result;
  status_u               alu_status;
  status_u               data_status;

  step_timer step_timer_i (
    .clock_i (clock_i),
    .reset_i (reset_i),
    .step_o  (step)
  );

  cpu_control cpu_control_i (
    .clock_i      (clock_i),
    .reset_i      (reset_i),
    .step_i       (step),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .ctrl_o       (ctrl)
  );

  cpu_datapath cpu_datapath_i (
    .clock_i       (clock_i),
    .reset_i       (reset_i),
    .ctrl_i        (ctrl),
    .data_i        (data_i),
    .alu_result_i  (alu_result),
    .alu_status_i  (alu_status),
    .data_status_i (data_status),
    .regs_o        (regs_o),
    .bus_o         (bus_o)
  );

  // Immediate operand comes straight off the bus
  cpu_alu cpu_alu_i (
    .a_i           (regs_o.a),
    .b_i           (data_i),
    .data_i        (data_i),
    .op_i          (ctrl.alu_op),
    .status_i      (regs_o.status),
    .result_o      (alu_result),
    .alu_status_o  (alu_status),
    .data_status_o (data_status)
  );

endmodule

//--- tb_cpu_memory.sv
module tb_cpu_memory
  import cpu_bus_pkg::*;
(
  input  logic                  clock_i,
  input  logic                  fast_i,
  input  bus_req_t              bus_i,
  output logic [DATA_WIDTH-1:0] data_o,
  output logic                  data_valid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LOG_DEPTH = 256;
  localparam int MAX_DELAY = 30;

  logic [DATA_WIDTH-1:0] mem [0:(1 << ADDR_WIDTH) - 1];
  logic [ADDR_WIDTH-1:0] log_addr [0:LOG_DEPTH-1];
  logic [DATA_WIDTH-1:0] log_data [0:LOG_DEPTH-1];
  int                    log_count;
  logic [ADDR_WIDTH-1:0] last_addr;
  logic                  last_read;
  logic                  last_write;
  int                    wait_left;

  initial begin
    data_o       = '0;
    data_valid_o = 1'b0;
    log_count    = 0;
    last_addr    = '0;
    last_read    = 1'b0;
    last_write   = 1'b0;
    wait_left    = 0;
  end

  always @(negedge clock_i) begin
    // One log entry per write, on its first cycle
    if (bus_i.write && !last_write) begin
      if (log_count < LOG_DEPTH) begin
        log_addr[log_count] = bus_i.address;
        log_data[log_count] = bus_i.write_data;
      end
      log_count = log_count + 1;
      mem[bus_i.address] = bus_i.write_data;
    end

    if (!bus_i.read) begin
      data_valid_o <= 1'b0;
    end else begin
      // New read address restarts the latency
      if (!last_read || bus_i.address != last_addr) begin
        wait_left = fast_i ? 0 : int'($urandom % (MAX_DELAY + 1));
      end else if (wait_left > 0) begin
        wait_left = wait_left - 1;
      end
      if (wait_left == 0) begin
        data_o       <= mem[bus_i.address];
        data_valid_o <= 1'b1;
      end else begin
        // Wrong byte while busy
        data_o       <= ~mem[bus_i.address];
        data_valid_o <= 1'b0;
      end
    end

    last_addr  = bus_i.address;
    last_read  = bus_i.read;
    last_write = bus_i.write;
  end

endmodule

//--- tb_cpu.sv
module tb_cpu
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          LOG_DEPTH    = 256;
  localparam int          WAIT_LIMIT   = 50000;
  localparam int          ARITH_COUNT  = 8;
  localparam int          CMP_COUNT    = 6;
  localparam logic [15:0] PROGRAM_BASE = 16'h0300;

  logic       clock;
  logic       reset;
  logic       fast_mode;
  logic [7:0] data;
  logic       data_valid;
  bus_req_t   bus;
  cpu_regs_t  regs;

  logic [7:0]  image [0:65535];
  logic [7:0]  ref_mem [0:65535];
  logic [15:0] exp_addr [0:LOG_DEPTH-1];
  logic [7:0]  exp_data [0:LOG_DEPTH-1];
  int          exp_count;
  logic [15:0] first_addr [0:LOG_DEPTH-1];
  logic [7:0]  first_data [0:LOG_DEPTH-1];
  int          first_count;
  logic [15:0] put_addr;
  logic [15:0] jump_addr;
  int          check_count;
  int          mismatch_count;
  int          failure_count;

  cpu_top cpu_top_i (
    .clock_i      (clock),
    .reset_i      (reset),
    .data_i       (data),
    .data_valid_i (data_valid),
    .bus_o        (bus),
    .regs_o       (regs)
  );

  tb_cpu_memory memory_i (
    .clock_i      (clock),
    .fast_i       (fast_mode),
    .bus_i        (bus),
    .data_o       (data),
    .data_valid_o (data_valid)
  );

  initial clock = 1'b0;
  always #20 clock = ~clock;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("** Error %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic wait_for_pc(input logic [15:0] target, input logic equal, output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && cycles < WAIT_LIMIT) begin
      @(negedge clock);
      if ((regs.pc == target) == equal) begin
        ok = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!ok) begin
      failure_count++;
      $display("Timeout: program counter did not %s 0x%0h within %0d cycles",
               equal ? "reach" : "leave", target, WAIT_LIMIT);
    end
  endtask

  function automatic status_u load_flags(input logic [7:0] value);
    status_u s;
    s.raw     = 8'h00;
    s.flags.z = (value == 8'h00);
    s.flags.n = value[7];
    return s;
  endfunction

  function automatic status_u arith_flags(input status_u old, input logic [7:0] value,
                                          input logic carry);
    status_u s;
    s         = old;
    s.flags.c = carry;
    s.flags.z = (value == 8'h00);
    s.flags.n = value[7];
    s.flags.v = 1'b0;
    return s;
  endfunction

  // Instruction-level model of the program in ref_mem
  function automatic cpu_regs_t run_reference();
    cpu_regs_t   r;
    logic [7:0]  op;
    logic [7:0]  arg;
    logic [15:0] target;
    int          result;
    int          count;
    logic        done;
    r.pc         = {ref_mem[16'hFFFD], ref_mem[16'hFFFC]};
    r.a          = 8'h00;
    r.x          = 8'h00;
    r.y          = 8'h00;
    r.sp         = 8'h00;
    r.status.raw = 8'h34;
    exp_count    = 0;
    done         = 1'b0;
    count        = 0;
    while (!done && count < 5000) begin
      op  = ref_mem[r.pc];
      arg = ref_mem[r.pc + 16'd1];
      count++;
      case (op)
        OP_LDA_IMM, OP_LDA_ZP: begin
          r.a      = (op == OP_LDA_ZP) ? ref_mem[{8'h00, arg}] : arg;
          r.status = load_flags(r.a);
        end
        OP_LDX_IMM, OP_LDX_ZP: begin
          r.x      = (op == OP_LDX_ZP) ? ref_mem[{8'h00, arg}] : arg;
          r.status = load_flags(r.x);
        end
        OP_LDY_IMM, OP_LDY_ZP: begin
          r.y      = (op == OP_LDY_ZP) ? ref_mem[{8'h00, arg}] : arg;
          r.status = load_flags(r.y);
        end
        OP_STA_ZP: begin
          ref_mem[{8'h00, arg}] = r.a;
          if (exp_count < LOG_DEPTH) begin
            exp_addr[exp_count] = {8'h00, arg};
            exp_data[exp_count] = r.a;
          end
          exp_count++;
        end
        OP_ADC_IMM: begin
          result   = int'(r.a) + int'(arg) + int'(r.status.flags.c);
          r.a      = 8'(result);
          r.status = arith_flags(r.status, r.a, result > 255);
        end
        OP_SBC_IMM: begin
          // Borrow is the missing carry
          result   = int'(r.a) - int'(arg) - (r.status.flags.c ? 0 : 1);
          r.a      = 8'(result);
          r.status = arith_flags(r.status, r.a, result >= 0);
        end
        OP_CMP_IMM: begin
          result   = int'(r.a) - int'(arg);
          r.status = arith_flags(r.status, 8'(result), r.a >= arg);
        end
        OP_TAX: r.x = r.a;
        OP_TAY: r.y = r.a;
        OP_TXA: r.a = r.x;
        OP_TYA: r.a = r.y;
        OP_TXS: r.sp = r.x;
        OP_TSX: r.x = r.sp;
        OP_SEC: r.status.flags.c = 1'b1;
        OP_CLC: r.status.flags.c = 1'b0;
        OP_NOP: ;
        OP_JMP_ABS: begin
          target = {ref_mem[r.pc + 16'd2], arg};
          done   = (target == r.pc);
          r.pc   = target;
        end
        default: done = 1'b1;
      endcase
      case (op)
        OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TXS, OP_TSX, OP_SEC, OP_CLC, OP_NOP:
          r.pc = r.pc + 16'd1;
        OP_JMP_ABS: ;
        default: r.pc = r.pc + 16'd2;
      endcase
    end
    return r;
  endfunction

  task automatic clear_image();
    int i;
    for (i = 0; i < 65536; i++) begin
      image[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
    end
    image[16'hFFFC] = PROGRAM_BASE[7:0];
    image[16'hFFFD] = PROGRAM_BASE[15:8];
    put_addr        = PROGRAM_BASE;
  endtask

  task automatic put_byte(input logic [7:0] value);
    image[put_addr] = value;
    put_addr        = put_addr + 16'd1;
  endtask

  task automatic put_two(input logic [7:0] op, input logic [7:0] arg);
    put_byte(op);
    put_byte(arg);
  endtask

  task automatic put_jump_to_self();
    jump_addr = put_addr;
    put_byte(OP_JMP_ABS);
    put_byte(jump_addr[7:0]);
    put_byte(jump_addr[15:8]);
  endtask

  task automatic build_transfer_program();
    clear_image();
    image[16'h0020] = 8'h7E;
    image[16'h0021] = 8'h00;
    put_two(OP_LDA_IMM, 8'hC3);
    put_two(OP_STA_ZP, 8'h10);
    put_two(OP_LDX_IMM, 8'h5A);
    put_two(OP_LDY_IMM, 8'h81);
    put_byte(OP_TYA);
    put_two(OP_STA_ZP, 8'h15);
    put_two(OP_LDA_ZP, 8'h20);
    put_two(OP_STA_ZP, 8'h16);
    put_two(OP_LDX_ZP, 8'h21);
    // Reads back the byte stored above
    put_two(OP_LDY_ZP, 8'h10);
    put_byte(OP_TXA);
    put_two(OP_STA_ZP, 8'h11);
    put_byte(OP_TYA);
    put_two(OP_STA_ZP, 8'h12);
    put_two(OP_LDX_IMM, 8'hF0);
    put_byte(OP_TXS);
    put_two(OP_LDA_IMM, 8'h3C);
    put_byte(OP_TAX);
    put_byte(OP_TAY);
    // A comes back through X
    put_byte(OP_TXA);
    put_two(OP_STA_ZP, 8'h13);
    put_byte(OP_TSX);
    put_byte(OP_TXA);
    put_two(OP_STA_ZP, 8'h14);
    put_byte(OP_SEC);
    put_byte(OP_NOP);
    put_jump_to_self();
  endtask

  task automatic build_arith_program();
    int         i;
    logic [7:0] zp;
    logic [7:0] a_value;
    clear_image();
    zp = 8'h40;
    for (i = 0; i < ARITH_COUNT; i++) begin
      put_two(OP_LDA_IMM, 8'($urandom));
      // Carry in is chosen after the load
      put_byte(($urandom % 2) ? OP_SEC : OP_CLC);
      put_two(($urandom % 2) ? OP_SBC_IMM : OP_ADC_IMM, 8'($urandom));
      put_two(OP_STA_ZP, zp);
      // Carry out shows up in the second store
      put_two(OP_ADC_IMM, 8'h00);
      put_two(OP_STA_ZP, zp + 8'd1);
      zp = zp + 8'd2;
    end
    for (i = 0; i < CMP_COUNT; i++) begin
      a_value = 8'($urandom);
      put_two(OP_LDA_IMM, a_value);
      put_two(OP_CMP_IMM, (i == 0) ? a_value : 8'($urandom));
      put_two(OP_STA_ZP, zp);
      // Last compare leaves its flags for the final check
      if (i != CMP_COUNT - 1) begin
        put_two(OP_ADC_IMM, 8'h00);
        put_two(OP_STA_ZP, zp + 8'd1);
      end
      zp = zp + 8'd2;
    end
    put_jump_to_self();
  endtask

  task automatic compare_run(input cpu_regs_t expected);
    int i;
    check_value("write count", memory_i.log_count, exp_count);
    for (i = 0; i < exp_count && i < memory_i.log_count && i < LOG_DEPTH; i++) begin
      check_value($sformatf("write %0d address", i), memory_i.log_addr[i], exp_addr[i]);
      check_value($sformatf("write %0d data", i), memory_i.log_data[i], exp_data[i]);
    end
    check_value("regs_o.pc", regs.pc, expected.pc);
    check_value("regs_o.a", regs.a, expected.a);
    check_value("regs_o.x", regs.x, expected.x);
    check_value("regs_o.y", regs.y, expected.y);
    check_value("regs_o.sp", regs.sp, expected.sp);
    check_value("regs_o.status", regs.status.raw, expected.status.raw);
  endtask

  task automatic run_program(input logic fast);
    cpu_regs_t expected;
    logic      ok;
    int        i;
    @(negedge clock);
    reset     = 1'b1;
    fast_mode = fast;
    for (i = 0; i < 65536; i++) begin
      memory_i.mem[i] = image[i];
      ref_mem[i]      = image[i];
    end
    memory_i.log_count = 0;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    check_value("bus_o.read after reset", bus.read, 1'b1);
    check_value("bus_o.write after reset", bus.write, 1'b0);
    check_value("bus_o.address after reset", bus.address, 16'hFFFC);
    check_value("regs_o.a after reset", regs.a, 8'h00);
    check_value("regs_o.x after reset", regs.x, 8'h00);
    check_value("regs_o.y after reset", regs.y, 8'h00);
    check_value("regs_o.sp after reset", regs.sp, 8'h00);
    check_value("regs_o.status after reset", regs.status.raw, 8'h34);

    expected = run_reference();
    // Fetch of the jump, its operand, then back at the jump
    wait_for_pc(jump_addr, 1'b1, ok);
    if (ok) begin
      wait_for_pc(jump_addr, 1'b0, ok);
    end
    if (ok) begin
      wait_for_pc(jump_addr, 1'b1, ok);
    end
    if (ok) begin
      compare_run(expected);
    end
  endtask

  task automatic save_first_log();
    int i;
    first_count = memory_i.log_count;
    for (i = 0; i < LOG_DEPTH; i++) begin
      first_addr[i] = memory_i.log_addr[i];
      first_data[i] = memory_i.log_data[i];
    end
  endtask

  task automatic compare_with_first_run();
    int i;
    check_value("write count without stalls", memory_i.log_count, first_count);
    for (i = 0; i < first_count && i < memory_i.log_count && i < LOG_DEPTH; i++) begin
      check_value($sformatf("write %0d address without stalls", i),
                  memory_i.log_addr[i], first_addr[i]);
      check_value($sformatf("write %0d data without stalls", i),
                  memory_i.log_data[i], first_data[i]);
    end
  endtask

  initial begin
    void'($urandom(16426));
    reset          = 1'b1;
    fast_mode      = 1'b0;
    check_count    = 0;
    mismatch_count = 0;
    failure_count  = 0;

    build_transfer_program();
    run_program(1'b0);

    build_arith_program();
    run_program(1'b0);
    save_first_log();
    // Same image with no read latency
    run_program(1'b1);
    compare_with_first_run();

    $display("Checks: %0d, mismatches: %0d, other failures: %0d",
             check_count, mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- filelist.f
cpu_isa_pkg.sv
cpu_bus_pkg.sv
step_timer.sv
cpu_alu.sv
cpu_control.sv
cpu_datapath.sv
cpu_top.sv
tb_cpu_memory.sv
tb_cpu.sv
